//--- common/board_pkg.sv
package board_pkg;

  // bus geometry
  localparam int addr_width = 12;  // 4k byte space
  localparam int data_width = 16;  // one instruction word

  typedef logic [addr_width-1:0] bus_addr_t;
  typedef logic [data_width-1:0] bus_word_t;

  // one request on the shared bus
  typedef struct packed {
    bus_addr_t addr;
    logic      wr;       // 1 = write
    logic      byt;      // 1 = byte access, data in low byte
    bus_word_t wr_data;
  } bus_req_t;

  // read data, one cycle after the request
  typedef struct packed {
    bus_word_t rd_data;
  } bus_rsp_t;

  // address map
  localparam bus_addr_t io_base       = 12'h080;  // {lcd, led}
  localparam bus_addr_t io_hi         = 12'h081;  // lcd only, from high byte
  localparam bus_addr_t io_window_end = 12'h0ff;  // io window is io_base..here
  localparam bus_addr_t load_base     = 12'h300;  // loader start address

  localparam bus_word_t load_end_word = 16'h7fff;  // end of program marker

  // loader fsm
  typedef enum logic [1:0] {
    ld_high,   // wait for high byte
    ld_low,    // wait for low byte
    ld_write   // word waits for the bus
  } loader_state_t;

  // round robin owner
  typedef enum logic {
    gnt_host,
    gnt_loader
  } grant_t;

endpackage

//--- hdl/word_loader.sv
`timescale 1ns/10ps

module word_loader import board_pkg::*; (
  input  logic            sys_clk,
  input  logic            rst_n,
  input  logic [7:0]      in_byte,
  input  logic            byte_valid,
  input  logic            ld_ready,
  output logic            byte_ready,
  output bus_req_t        ld_req,
  output logic            ld_valid,
  output logic            load_done,
  output bus_word_t [2:0] last_words  // [0] is newest
);

  loader_state_t state;
  logic [7:0]    hi_byte;   // first byte of the pair
  bus_word_t     word_q;    // word waiting for the bus
  bus_addr_t     ld_addr;   // next write address
  bus_word_t     word_in;
  logic          byte_acc;
  logic          word_acc;  // second byte taken this cycle

  assign byte_ready = (state != ld_write);  // stall while write pending
  assign byte_acc   = byte_valid && byte_ready;
  assign word_acc   = byte_acc && (state == ld_low);
  assign word_in    = {hi_byte, in_byte};  // high byte came first
  assign ld_valid   = (state == ld_write);

  // always a word write
  always_comb begin
    ld_req.addr    = ld_addr;
    ld_req.wr      = 1'b1;
    ld_req.byt     = 1'b0;
    ld_req.wr_data = word_q;
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= ld_high;
      ld_addr   <= load_base;
      load_done <= 1'b0;
    end else begin
      case (state)
        ld_high: if (byte_acc) state <= ld_low;
        ld_low: begin
          if (byte_acc) begin
            if (word_in == load_end_word) begin
              // terminator, no write and restart at base
              state     <= ld_high;
              ld_addr   <= load_base;
              load_done <= 1'b1;
            end else begin
              state     <= ld_write;
              load_done <= 1'b0;  // a new program starts
            end
          end
        end
        ld_write: begin
          if (ld_ready) begin
            state   <= ld_high;
            ld_addr <= ld_addr + bus_addr_t'(2);  // next even address
          end
        end
        default: state <= ld_high;
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (byte_acc && state == ld_high) hi_byte <= in_byte;
    if (word_acc) word_q <= word_in;
  end

  // display history, terminator included
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n)
      last_words <= '0;
    else if (word_acc)
      last_words <= {last_words[1:0], word_in};
  end

endmodule

//--- hdl/bus_arbiter.sv
`timescale 1ns/10ps

module bus_arbiter import board_pkg::*; (
  input  logic     sys_clk,
  input  logic     rst_n,
  input  bus_req_t host_req,
  input  logic     host_valid,
  input  bus_req_t ld_req,
  input  logic     ld_valid,
  input  bus_rsp_t rd_rsp,
  output logic     host_ready,
  output logic     ld_ready,
  output bus_req_t bus_req,
  output logic     bus_valid,
  output bus_rsp_t host_rsp,
  output logic     host_rsp_valid
);

  grant_t last_gnt;   // most recent winner
  grant_t rsp_owner;  // who gets the pending read data
  logic   rsp_pend;   // read accepted last cycle
  logic   gnt_h;
  logic   gnt_l;

  // single grant per cycle, loser of the last tie wins the next one
  always_comb begin
    gnt_h = 1'b0;
    gnt_l = 1'b0;
    if (host_valid && ld_valid) begin
      if (last_gnt == gnt_host)
        gnt_l = 1'b1;
      else
        gnt_h = 1'b1;
    end else begin
      gnt_h = host_valid;  // lone requester goes at once
      gnt_l = ld_valid;
    end
  end

  assign host_ready = gnt_h;
  assign ld_ready   = gnt_l;
  assign bus_valid  = gnt_h || gnt_l;
  assign bus_req    = gnt_l ? ld_req : host_req;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      last_gnt  <= gnt_host;
      rsp_owner <= gnt_host;
      rsp_pend  <= 1'b0;
    end else begin
      if (bus_valid) last_gnt <= gnt_l ? gnt_loader : gnt_host;
      rsp_pend  <= bus_valid && !bus_req.wr;
      rsp_owner <= gnt_l ? gnt_loader : gnt_host;
    end
  end

  // loader never reads, so its responses just fall away
  assign host_rsp       = rd_rsp;
  assign host_rsp_valid = rsp_pend && (rsp_owner == gnt_host);

endmodule

//--- mem/byte_lane_ram.sv
`timescale 1ns/10ps

module byte_lane_ram import board_pkg::*; #(
  parameter int ram_words = 2048
) (
  input  logic      sys_clk,
  input  bus_req_t  bus_req,
  input  logic      wr_en,
  output bus_word_t ram_word
);

  localparam int idx_w = $clog2(ram_words);

  // even address = low byte, odd address = high byte
  logic [7:0] bank_even [ram_words];
  logic [7:0] bank_odd  [ram_words];

  logic [idx_w-1:0] idx;
  logic             wr_even;
  logic             wr_odd;
  logic [7:0]       din_odd;
  logic [7:0]       rd_even;
  logic [7:0]       rd_odd;

  assign idx = bus_req.addr[idx_w:1];  // word index, bit 0 picks the lane

  // word write hits both lanes, byte write only the addressed one
  assign wr_even = wr_en && (!bus_req.byt || !bus_req.addr[0]);
  assign wr_odd  = wr_en && (!bus_req.byt || bus_req.addr[0]);

  // byte data always arrives in the low byte
  assign din_odd = bus_req.byt ? bus_req.wr_data[7:0] : bus_req.wr_data[15:8];

  always_ff @(posedge sys_clk) begin
    if (wr_even) bank_even[idx] <= bus_req.wr_data[7:0];
    rd_even <= bank_even[idx];  // old data on a same-cycle write
  end

  always_ff @(posedge sys_clk) begin
    if (wr_odd) bank_odd[idx] <= din_odd;
    rd_odd <= bank_odd[idx];
  end

  assign ram_word = {rd_odd, rd_even};  // valid one cycle after the address

endmodule

//--- hdl/io_regs.sv
`timescale 1ns/10ps

module io_regs import board_pkg::*; (
  input  logic       sys_clk,
  input  logic       rst_n,
  input  bus_req_t   bus_req,
  input  logic       bus_valid,
  input  bus_word_t  ram_word,
  output logic       ram_wr_en,
  output bus_rsp_t   rd_rsp,
  output logic [7:0] io_led,
  output logic [7:0] io_lcd,
  output bus_addr_t  last_addr
);

  logic in_win;  // request falls in the io window
  logic bus_wr;

  assign in_win    = (bus_req.addr >= io_base) && (bus_req.addr <= io_window_end);
  assign bus_wr    = bus_valid && bus_req.wr;
  assign ram_wr_en = bus_wr && !in_win;  // io space never reaches the ram

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      io_led <= 8'h00;
      io_lcd <= 8'h00;
    end else if (bus_wr && bus_req.addr == io_base) begin
      if (bus_req.byt)
        io_led <= bus_req.wr_data[7:0];  // byte write, led only
      else
        {io_lcd, io_led} <= bus_req.wr_data;
    end else if (bus_wr && bus_req.addr == io_hi) begin
      io_lcd <= bus_req.wr_data[15:8];
    end
  end

  // address of the accepted request, lines up with the ram read
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n)
      last_addr <= '0;
    else if (bus_valid)
      last_addr <= bus_req.addr;
  end

  // read mux
  always_comb begin
    if (last_addr == io_base || last_addr == io_hi)
      rd_rsp.rd_data = {io_lcd, io_led};
    else if (last_addr >= io_base && last_addr <= io_window_end)
      rd_rsp.rd_data = '0;  // empty io space
    else
      rd_rsp.rd_data = ram_word;
  end

endmodule

//--- hdl/led_scan.sv
`timescale 1ns/10ps

module led_scan import board_pkg::*; #(
  parameter int scan_period = 27000,
  parameter int gap_on      = 100,
  parameter int gap_off     = 2000
) (
  input  logic            sys_clk,
  input  logic            rst_n,
  input  bus_word_t [2:0] last_words,
  input  bus_addr_t       last_addr,
  output logic [8:0]      led_row,   // active low
  output logic [7:0]      led_col
);

  localparam int cnt_w = $clog2(scan_period);
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(scan_period - 1);
  localparam logic [cnt_w-1:0] on_start = cnt_w'(gap_on);
  localparam logic [cnt_w-1:0] on_stop  = cnt_w'(scan_period - gap_off);

  logic [cnt_w-1:0] cnt;      // position inside one row period
  logic [3:0]       row_idx;  // 0..8
  logic             row_on;
  logic [8:0]       row_sel;

  // segments a..g in bits 7..1, dot in bit 0
  function automatic logic [7:0] seg7(input logic [4:0] n);
    logic [6:0] seg;
    case (n[3:0])
      4'h0: seg = 7'b1111110;
      4'h1: seg = 7'b0110000;
      4'h2: seg = 7'b1101101;
      4'h3: seg = 7'b1111001;
      4'h4: seg = 7'b0110011;
      4'h5: seg = 7'b1011011;
      4'h6: seg = 7'b1011111;
      4'h7: seg = 7'b1110010;
      4'h8: seg = 7'b1111111;
      4'h9: seg = 7'b1111011;
      4'ha: seg = 7'b1110111;
      4'hb: seg = 7'b0011111;
      4'hc: seg = 7'b1001110;
      4'hd: seg = 7'b0111101;
      4'he: seg = 7'b1001111;
      default: seg = 7'b1000111;  // f
    endcase
    return {seg, n[4]};
  endfunction

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt     <= '0;
      row_idx <= 4'd0;
    end else if (cnt == cnt_last) begin
      cnt     <= '0;
      row_idx <= (row_idx == 4'd8) ? 4'd0 : row_idx + 4'd1;  // next row
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // dark gap at both ends of the period keeps neighbours from ghosting
  assign row_on  = (cnt >= on_start) && (cnt < on_stop);
  assign row_sel = 9'd1 << row_idx;
  assign led_row = row_on ? ~row_sel : '1;

  always_comb begin
    case (row_idx)
      4'd0: led_col = last_words[0][15:8];  // newest word
      4'd1: led_col = last_words[0][7:0];
      4'd2: led_col = last_words[1][15:8];
      4'd3: led_col = last_words[1][7:0];
      4'd4: led_col = last_words[2][15:8];
      4'd5: led_col = last_words[2][7:0];
      4'd6: led_col = {4'h0, last_addr[11:8]};
      4'd7: led_col = last_addr[7:0];
      4'd8: led_col = seg7(last_addr[4:0]);
      default: led_col = 8'h00;
    endcase
  end

endmodule

//--- hdl/board_top.sv
`timescale 1ns/10ps

module board_top import board_pkg::*; #(
  parameter int ram_words   = 2048,
  parameter int scan_period = 27000,  // one row period in clocks
  parameter int gap_on      = 100,
  parameter int gap_off     = 2000
) (
  input  logic       sys_clk,
  input  logic       rst_n,
  input  bus_req_t   host_req,
  input  logic       host_valid,
  input  logic [7:0] in_byte,
  input  logic       byte_valid,
  output logic       host_ready,
  output bus_rsp_t   host_rsp,
  output logic       host_rsp_valid,
  output logic       byte_ready,
  output logic       load_done,
  output logic [7:0] led_col,
  output logic [8:0] led_row,
  output logic       lcd_e,
  output logic       lcd_rw,
  output logic       lcd_rs,
  output logic [3:0] lcd_db,
  output logic [7:0] io_led
);

  bus_req_t        ld_req;
  logic            ld_valid;
  logic            ld_ready;
  bus_req_t        bus_req;    // granted request
  logic            bus_valid;
  bus_rsp_t        rd_rsp;
  bus_word_t       ram_word;   // raw ram read
  logic            ram_wr_en;
  logic [7:0]      io_lcd;
  bus_addr_t       last_addr;
  bus_word_t [2:0] last_words;

  // lcd byte straight to pins, bit 3 unused
  assign lcd_e  = io_lcd[0];
  assign lcd_rw = io_lcd[1];
  assign lcd_rs = io_lcd[2];
  assign lcd_db = io_lcd[7:4];

  word_loader word_loader_i (
    .sys_clk(sys_clk), .rst_n(rst_n), .in_byte(in_byte), .byte_valid(byte_valid),
    .ld_ready(ld_ready), .byte_ready(byte_ready), .ld_req(ld_req), .ld_valid(ld_valid),
    .load_done(load_done), .last_words(last_words)
  );

  bus_arbiter bus_arbiter_i (
    .sys_clk(sys_clk), .rst_n(rst_n), .host_req(host_req), .host_valid(host_valid),
    .ld_req(ld_req), .ld_valid(ld_valid), .rd_rsp(rd_rsp), .host_ready(host_ready),
    .ld_ready(ld_ready), .bus_req(bus_req), .bus_valid(bus_valid),
    .host_rsp(host_rsp), .host_rsp_valid(host_rsp_valid)
  );

  byte_lane_ram #(.ram_words(ram_words)) byte_lane_ram_i (
    .sys_clk(sys_clk), .bus_req(bus_req), .wr_en(ram_wr_en), .ram_word(ram_word)
  );

  io_regs io_regs_i (
    .sys_clk(sys_clk), .rst_n(rst_n), .bus_req(bus_req), .bus_valid(bus_valid),
    .ram_word(ram_word), .ram_wr_en(ram_wr_en), .rd_rsp(rd_rsp), .io_led(io_led),
    .io_lcd(io_lcd), .last_addr(last_addr)
  );

  led_scan #(
    .scan_period(scan_period), .gap_on(gap_on), .gap_off(gap_off)
  ) led_scan_i (
    .sys_clk(sys_clk), .rst_n(rst_n), .last_words(last_words), .last_addr(last_addr),
    .led_row(led_row), .led_col(led_col)
  );

endmodule

//--- dv/board_clk_gen.sv
`timescale 1ns/10ps

module board_clk_gen #(
  parameter int half_period = 5,  // ns, 10 ns clock
  parameter int rst_cycles  = 8
) (
  output logic sys_clk,
  output logic rst_n
);

  initial begin
    sys_clk = 1'b0;
    forever #(half_period) sys_clk = ~sys_clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (rst_cycles) @(posedge sys_clk);
    #1 rst_n = 1'b1;  // off the edge like every other input
  end

endmodule

//--- dv/board_chk.sv
`timescale 1ns/10ps

module board_chk import board_pkg::*; (
  input logic     sys_clk,
  input logic     rst_n,
  input bus_req_t host_req,
  input logic     host_valid,
  input logic     host_ready,
  input logic     host_rsp_valid,
  input bus_req_t ld_req,
  input logic     ld_valid,
  input logic     ld_ready,
  input logic [7:0] in_byte,
  input logic     byte_valid,
  input logic     byte_ready,
  input logic [8:0] led_row
);

  logic       odd_byte;  // high byte of a pair already taken
  logic [7:0] hi_seen;
  logic       wr_pend;   // word complete, bus write not yet granted

  // pending write seen from the byte and bus handshakes only
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      odd_byte <= 1'b0;
      hi_seen  <= 8'h00;
      wr_pend  <= 1'b0;
    end else begin
      if (byte_valid && byte_ready) begin
        odd_byte <= !odd_byte;
        if (!odd_byte)
          hi_seen <= in_byte;
        else if ({hi_seen, in_byte} != load_end_word)
          wr_pend <= 1'b1;  // terminator makes no write
      end
      if (ld_valid && ld_ready) wr_pend <= 1'b0;
    end
  end

  // accepted host read gives a response on the next cycle
  a_rsp_follows: assert property (@(posedge sys_clk) disable iff (!rst_n)
    (host_valid && host_ready && !host_req.wr) |=> host_rsp_valid)
    else $error("host read accepted without a response one cycle later");

  // and no response without such a read
  a_rsp_origin: assert property (@(posedge sys_clk) disable iff (!rst_n)
    host_rsp_valid |-> $past(host_valid && host_ready && !host_req.wr))
    else $error("host response without an accepted read");

  a_host_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
    (host_valid && !host_ready) |=> (host_valid && $stable(host_req)))
    else $error("host request changed while stalled");

  a_ld_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
    (ld_valid && !ld_ready) |=> (ld_valid && $stable(ld_req)))
    else $error("loader request changed while stalled");

  a_row_onehot: assert property (@(posedge sys_clk) disable iff (!rst_n)
    $countones(~led_row) <= 1)
    else $error("more than one led row driven");

  a_ld_stall: assert property (@(posedge sys_clk) disable iff (!rst_n)
    wr_pend |-> (ld_valid && !byte_ready))
    else $error("byte_ready high while loader write pending");

endmodule

//--- dv/board_tb.sv
`timescale 1ns/10ps

module board_tb import board_pkg::*; ();

  localparam int tmo = 200;  // cycles allowed per handshake

  logic       sys_clk;
  logic       rst_n;
  bus_req_t   host_req;
  logic       host_valid;
  logic [7:0] in_byte;
  logic       byte_valid;
  logic       host_ready;
  bus_rsp_t   host_rsp;
  logic       host_rsp_valid;
  logic       byte_ready;
  logic       load_done;
  logic [7:0] led_col;
  logic [8:0] led_row;
  logic       lcd_e;
  logic       lcd_rw;
  logic       lcd_rs;
  logic [3:0] lcd_db;
  logic [7:0] io_led;

  // reference model state
  logic [7:0]  m_mem [4096];  // byte per address
  logic [7:0]  m_led;
  logic [7:0]  m_lcd;
  bus_addr_t   m_ld_addr;
  bus_word_t   m_hist [3];    // [0] newest
  logic        m_done;
  bus_addr_t   m_last_addr;

  logic [31:0] seed = 32'h721a;
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_failed;

  // segments a..g in bits 7..1, dot bit left clear
  localparam logic [7:0] seg_tab [16] = '{
    8'hfc, 8'h60, 8'hda, 8'hf2, 8'h66, 8'hb6, 8'hbe, 8'he4,
    8'hfe, 8'hf6, 8'hee, 8'h3e, 8'h9c, 8'h7a, 8'h9e, 8'h8e
  };

  board_clk_gen #(.half_period(5), .rst_cycles(8)) board_clk_gen_i (
    .sys_clk(sys_clk), .rst_n(rst_n)
  );

  board_top #(.scan_period(40), .gap_on(4), .gap_off(8)) board_top_i (.*);

  bind board_top board_chk board_chk_i (.*);

  function automatic logic [31:0] rand_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return {seed[15:0], seed[31:16]};  // upper bits land low
  endfunction

  function automatic bus_word_t prog_word();  // random, never the terminator
    logic [31:0] r;
    r = rand_next();
    return (r[15:0] == load_end_word) ? 16'h1234 : r[15:0];
  endfunction

  function automatic bus_word_t model_read(bus_addr_t a);
    if (a == io_base || a == io_hi)
      return {m_lcd, m_led};
    if (a >= io_base && a <= io_window_end)
      return '0;  // empty io space
    return {m_mem[a | 12'h001], m_mem[a & 12'hffe]};
  endfunction

  task automatic model_write(bus_addr_t a, logic byt, bus_word_t d);
    if (a == io_base) begin
      m_led = d[7:0];
      if (!byt) m_lcd = d[15:8];
    end else if (a == io_hi) begin
      m_lcd = d[15:8];
    end else if (a < io_base || a > io_window_end) begin
      if (byt) begin
        m_mem[a] = d[7:0];  // lane by address bit 0
      end else begin
        m_mem[a & 12'hffe] = d[7:0];
        m_mem[a | 12'h001] = d[15:8];
      end
    end
  endtask

  task automatic model_word(bus_word_t w);
    m_hist[2] = m_hist[1];
    m_hist[1] = m_hist[0];
    m_hist[0] = w;  // terminator shows up too
    if (w == load_end_word) begin
      m_done    = 1'b1;
      m_ld_addr = load_base;
    end else begin
      model_write(m_ld_addr, 1'b0, w);
      m_ld_addr = m_ld_addr + 12'd2;
      m_done    = 1'b0;
    end
  endtask

  task automatic log_mismatch(string sig, logic [15:0] got, logic [15:0] exp);
    errors++;
    $display("FAIL at %0t: %s got %h expected %h", $time, sig, got, exp);
  endtask

  task automatic note_timeout(string what);
    errors++;
    $display("timeout at %0t: %s did not come within %0d cycles", $time, what, tmo);
  endtask

  task automatic check_rsp(bus_addr_t a, bus_rsp_t got, bus_rsp_t exp);
    checks++;
    if (got !== exp)
      log_mismatch($sformatf("host_rsp.rd_data @%h", a), got.rd_data, exp.rd_data);
  endtask

  task automatic check_io(logic [7:0] exp_led, logic [7:0] exp_lcd);
    checks++;
    if (io_led !== exp_led) log_mismatch("io_led", io_led, exp_led);
    if ({lcd_db, lcd_rs, lcd_rw, lcd_e} !== {exp_lcd[7:4], exp_lcd[2:0]})  // bit 3 has no pin
      log_mismatch("lcd pins", {lcd_db, lcd_rs, lcd_rw, lcd_e}, {exp_lcd[7:4], exp_lcd[2:0]});
  endtask

  task automatic check_row(int k, logic [7:0] got);
    logic [7:0] exp;
    if (k < 6)
      exp = k[0] ? m_hist[k / 2][7:0] : m_hist[k / 2][15:8];  // high byte first
    else if (k == 6)
      exp = {4'h0, m_last_addr[11:8]};
    else if (k == 7)
      exp = m_last_addr[7:0];
    else
      exp = seg_tab[m_last_addr[3:0]] | {7'b0, m_last_addr[4]};
    checks++;
    if (got !== exp) log_mismatch($sformatf("led_col row %0d", k), got, exp);
  endtask

  task automatic check_flag(string sig, logic got, logic exp);
    checks++;
    if (got !== exp) log_mismatch(sig, got, exp);
  endtask

  task automatic host_xfer(bus_req_t req);
    int n;
    @(posedge sys_clk);
    #1;
    host_req   = req;
    host_valid = 1'b1;
    n = 0;
    @(negedge sys_clk);
    while (!host_ready && n < tmo) begin
      @(negedge sys_clk);
      n++;
    end
    if (!host_ready) note_timeout("host_ready");
    @(posedge sys_clk);  // transfer edge
    #1;
    host_valid  = 1'b0;
    m_last_addr = req.addr;
  endtask

  task automatic host_write(bus_addr_t a, logic byt, bus_word_t d);
    bus_req_t req;
    req = '{addr: a, wr: 1'b1, byt: byt, wr_data: d};
    host_xfer(req);
    model_write(a, byt, d);
  endtask

  task automatic host_read_check(bus_addr_t a);
    bus_req_t req;
    bus_rsp_t exp;
    int       n;
    req = '{addr: a, wr: 1'b0, byt: 1'b0, wr_data: '0};
    exp.rd_data = model_read(a);
    host_xfer(req);
    n = 0;
    @(negedge sys_clk);
    while (!host_rsp_valid && n < tmo) begin
      @(negedge sys_clk);
      n++;
    end
    if (!host_rsp_valid) note_timeout("host_rsp_valid");
    else check_rsp(a, host_rsp, exp);
  endtask

  task automatic host_random_op();  // ram window 0x100..0x1ff
    logic [31:0] r;
    bus_addr_t   a;
    r = rand_next();
    a = 12'h100 | bus_addr_t'(r[7:0]);
    case (r[9:8])
      2'd0: host_write(a & 12'hffe, 1'b0, r[31:16]);
      2'd1: host_write(a, 1'b1, r[31:16]);  // high byte must be ignored
      default: host_read_check(a & 12'hffe);
    endcase
  endtask

  task automatic send_byte(logic [7:0] b);
    int n;
    repeat (rand_next() % 4) @(posedge sys_clk);  // idle gap
    @(posedge sys_clk);
    #1;
    in_byte    = b;
    byte_valid = 1'b1;
    n = 0;
    @(negedge sys_clk);
    while (!byte_ready && n < tmo) begin
      @(negedge sys_clk);
      n++;
    end
    if (!byte_ready) note_timeout("byte_ready");
    @(posedge sys_clk);
    #1;
    byte_valid = 1'b0;
  endtask

  task automatic send_word(bus_word_t w);
    send_byte(w[15:8]);
    send_byte(w[7:0]);
    model_word(w);
  endtask

  task automatic wait_loader_idle();
    int n;
    n = 0;
    @(negedge sys_clk);
    while (!byte_ready && n < tmo) begin
      @(negedge sys_clk);
      n++;
    end
    if (!byte_ready) note_timeout("loader write");
  endtask

  task automatic end_test(int num, string name, int err0);
    tests_run++;
    if (errors == err0) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", num, name, errors - err0);
    end
  endtask

  initial begin
    int          err0;
    int          n;
    logic [31:0] r;
    bus_addr_t   ra;
    logic [8:0]  seen;
    host_req   = '0;
    host_valid = 1'b0;
    in_byte    = 8'h00;
    byte_valid = 1'b0;
    errors = 0;
    checks = 0;
    tests_run = 0;
    tests_failed = 0;
    m_led = 8'h00;
    m_lcd = 8'h00;
    m_ld_addr = load_base;
    m_hist = '{16'h0, 16'h0, 16'h0};
    m_done = 1'b0;
    m_last_addr = '0;
    n = 0;
    while (rst_n !== 1'b1 && n < tmo) begin
      @(posedge sys_clk);
      n++;
    end
    if (rst_n !== 1'b1) note_timeout("reset release");
    #1;

    // 1: reset state, then random ram traffic
    err0 = errors;
    check_flag("host_rsp_valid", host_rsp_valid, 1'b0);
    check_flag("byte_ready", byte_ready, 1'b1);
    check_flag("load_done", load_done, 1'b0);
    check_flag("led_row idle", &led_row, 1'b1);
    check_io(8'h00, 8'h00);
    for (int i = 0; i < 128; i++) begin
      r = rand_next();
      host_write(bus_addr_t'(12'h100 + 2 * i), 1'b0, r[15:0]);  // known contents first
    end
    for (int i = 0; i < 80; i++) host_random_op();
    end_test(1, "ram word and byte access", err0);

    // 2: io registers and window
    err0 = errors;
    r = rand_next();
    host_write(io_base, 1'b0, r[15:0]);
    check_io(m_led, m_lcd);
    host_write(io_base, 1'b1, r[31:16]);  // led only
    check_io(m_led, m_lcd);
    host_write(io_hi, 1'b0, ~r[15:0]);    // lcd from high byte
    check_io(m_led, m_lcd);
    host_read_check(io_base);
    host_read_check(io_hi);
    for (int i = 0; i < 6; i++) begin
      r  = rand_next();
      ra = 12'h040 | bus_addr_t'(r[5:0] & 6'h3e);
      host_write(ra, 1'b0, r[31:16]);
      host_write(ra | 12'h080, 1'b0, ~r[31:16]);  // alias inside the window
      host_read_check(ra | 12'h080);
      host_read_check(ra);
    end
    check_io(m_led, m_lcd);
    end_test(2, "io registers", err0);

    // 3: byte stream into words
    err0 = errors;
    for (int i = 0; i < 8; i++) send_word(prog_word());
    wait_loader_idle();
    for (int i = 0; i < 8; i++) host_read_check(bus_addr_t'(load_base + 2 * i));
    end_test(3, "loader word pairing", err0);

    // 4: terminator
    err0 = errors;
    ra = m_ld_addr;
    host_write(ra, 1'b0, 16'ha5c3);  // must survive the terminator
    send_word(load_end_word);
    wait_loader_idle();
    check_flag("load_done", load_done, m_done);
    host_read_check(ra);
    send_word(prog_word());
    wait_loader_idle();
    check_flag("load_done", load_done, m_done);
    host_read_check(load_base);
    end_test(4, "terminator and restart", err0);

    // 5: both masters at once
    err0 = errors;
    fork
      begin
        for (int i = 0; i < 24; i++) host_random_op();
      end
      begin
        for (int j = 0; j < 12; j++) send_word(prog_word());
      end
    join
    wait_loader_idle();
    for (int i = 0; i < 128; i++) host_read_check(bus_addr_t'(12'h100 + 2 * i));
    for (ra = load_base; ra < m_ld_addr; ra = ra + 12'd2) host_read_check(ra);
    end_test(5, "concurrent traffic", err0);

    // 6: led matrix content
    err0 = errors;
    r  = rand_next();
    host_read_check(12'h100 | bus_addr_t'(r[7:0] & 8'hfe));  // sets last_addr
    seen = '0;
    n = 0;
    while (seen != 9'h1ff && n < 9 * 40 * 3) begin
      @(negedge sys_clk);
      n++;
      for (int k = 0; k < 9; k++) begin
        if (!led_row[k]) begin
          check_row(k, led_col);
          seen[k] = 1'b1;
        end
      end
    end
    if (seen != 9'h1ff) note_timeout("full led scan");
    end_test(6, "led scan rows", err0);

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

//--- board.f
common/board_pkg.sv
hdl/word_loader.sv
hdl/bus_arbiter.sv
mem/byte_lane_ram.sv
hdl/io_regs.sv
hdl/led_scan.sv
hdl/board_top.sv
dv/board_clk_gen.sv
dv/board_chk.sv
dv/board_tb.sv

//--- Bender.yml
package:
  name: board

sources:
  - common/board_pkg.sv
  - hdl/word_loader.sv
  - hdl/bus_arbiter.sv
  - mem/byte_lane_ram.sv
  - hdl/io_regs.sv
  - hdl/led_scan.sv
  - hdl/board_top.sv
  - target: simulation
    files:
      - dv/board_clk_gen.sv
      - dv/board_chk.sv
      - dv/board_tb.sv
